//--- all.f
design/dualIssuePkg.sv
design/laneDecode.sv
design/regFile.sv
design/bypassUnit.sv
design/alu.sv
design/execLane.sv
design/dualAluCore.sv
testbench/dualAluCore_asserts.sv
testbench/dualAluCoreTb.sv

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  dualIssuePkg::dataWord a,
    input  dualIssuePkg::dataWord b,
    input  dualIssuePkg::aluOp    op,
    output dualIssuePkg::dataWord result
);
    import dualIssuePkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shifts use 5 bits

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSll:   result = a << shamt;
            aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
            aluSltu:  result = {31'b0, a < b};
            aluXor:   result = a ^ b;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $signed(a) >>> shamt;
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/bypassUnit.sv
`timescale 1ns/1ps
`default_nettype none

module bypassUnit (
    input  dualIssuePkg::regIndex srcA1,
    input  dualIssuePkg::regIndex srcA2,
    input  dualIssuePkg::regIndex srcB1,
    input  dualIssuePkg::regIndex srcB2,
    input  logic                  xmWriteA,
    input  dualIssuePkg::regIndex xmRdA,
    input  logic                  xmWriteB,
    input  dualIssuePkg::regIndex xmRdB,
    input  logic                  mwWriteA,
    input  dualIssuePkg::regIndex mwRdA,
    input  logic                  mwWriteB,
    input  dualIssuePkg::regIndex mwRdB,
    output dualIssuePkg::fwdSel   selA1,
    output dualIssuePkg::fwdSel   selA2,
    output dualIssuePkg::fwdSel   selB1,
    output dualIssuePkg::fwdSel   selB2
);
    import dualIssuePkg::*;

    // --------------------
    // newest older writer wins
    // order: xm B, xm A, mw B, mw A
    // --------------------
    function automatic fwdSel pickSource(input regIndex src);
        if (src == '0) begin
            return fromRegFile;  // x0 never bypassed
        end
        if (xmWriteB && xmRdB != '0 && xmRdB == src) begin
            return fromXmB;
        end
        if (xmWriteA && xmRdA != '0 && xmRdA == src) begin
            return fromXmA;
        end
        if (mwWriteB && mwRdB != '0 && mwRdB == src) begin
            return fromMwB;
        end
        if (mwWriteA && mwRdA != '0 && mwRdA == src) begin
            return fromMwA;
        end
        return fromRegFile;
    endfunction

    always_comb begin
        selA1 = pickSource(srcA1);
        selA2 = pickSource(srcA2);
        selB1 = pickSource(srcB1);
        selB2 = pickSource(srcB2);
    end

endmodule

`default_nettype wire

//--- design/dualAluCore.sv
`timescale 1ns/1ps
`default_nettype none

module dualAluCore (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issueValid,
    input  logic [31:0]           instrA,
    input  logic [31:0]           instrB,
    output logic                  wbEnableA,
    output dualIssuePkg::regIndex wbRegA,
    output dualIssuePkg::dataWord wbDataA,
    output logic                  wbEnableB,
    output dualIssuePkg::regIndex wbRegB,
    output dualIssuePkg::dataWord wbDataB
);
    import dualIssuePkg::*;

    logic    validA, validB;
    logic    writesRegA, writesRegB;
    logic    useImmA, useImmB;
    regIndex rs1A, rs2A, rdA;
    regIndex rs1B, rs2B, rdB;
    aluOp    opA, opB;
    dataWord immA, immB;
    dataWord readDataA1, readDataA2, readDataB1, readDataB2;
    regIndex srcA1, srcA2, srcB1, srcB2;
    fwdSel   selA1, selA2, selB1, selB2;
    logic    xmWriteA, xmWriteB;
    regIndex xmRdA, xmRdB;
    dataWord xmResultA, xmResultB;

    laneDecode decodeA (
        .clock(clock), .reset(reset), .issueValid(issueValid), .instr(instrA),
        .valid(validA), .rs1(rs1A), .rs2(rs2A), .rd(rdA), .writesReg(writesRegA),
        .op(opA), .useImm(useImmA), .imm(immA)
    );

    laneDecode decodeB (
        .clock(clock), .reset(reset), .issueValid(issueValid), .instr(instrB),
        .valid(validB), .rs1(rs1B), .rs2(rs2B), .rd(rdB), .writesReg(writesRegB),
        .op(opB), .useImm(useImmB), .imm(immB)
    );

    regFile regFile0 (
        .clock(clock), .reset(reset),
        .readRegA1(rs1A), .readRegA2(rs2A), .readRegB1(rs1B), .readRegB2(rs2B),
        .readDataA1(readDataA1), .readDataA2(readDataA2),
        .readDataB1(readDataB1), .readDataB2(readDataB2),
        .writeEnableA(wbEnableA), .writeRegA(wbRegA), .writeDataA(wbDataA),
        .writeEnableB(wbEnableB), .writeRegB(wbRegB), .writeDataB(wbDataB)
    );

    bypassUnit bypass0 (
        .srcA1(srcA1), .srcA2(srcA2), .srcB1(srcB1), .srcB2(srcB2),
        .xmWriteA(xmWriteA), .xmRdA(xmRdA), .xmWriteB(xmWriteB), .xmRdB(xmRdB),
        .mwWriteA(wbEnableA), .mwRdA(wbRegA), .mwWriteB(wbEnableB), .mwRdB(wbRegB),
        .selA1(selA1), .selA2(selA2), .selB1(selB1), .selB2(selB2)
    );

    execLane laneA (
        .clock(clock), .reset(reset), .isLaneB(1'b0),
        .valid(validA), .rs1(rs1A), .rs2(rs2A), .rd(rdA), .writesReg(writesRegA),
        .op(opA), .useImm(useImmA), .imm(immA),
        .regData1(readDataA1), .regData2(readDataA2), .sel1(selA1), .sel2(selA2),
        .otherXmResult(xmResultB), .otherMwResult(wbDataB),
        .src1(srcA1), .src2(srcA2),
        .xmWrite(xmWriteA), .xmRd(xmRdA), .xmResult(xmResultA),
        .mwWrite(wbEnableA), .mwRd(wbRegA), .mwResult(wbDataA)
    );

    execLane laneB (
        .clock(clock), .reset(reset), .isLaneB(1'b1),
        .valid(validB), .rs1(rs1B), .rs2(rs2B), .rd(rdB), .writesReg(writesRegB),
        .op(opB), .useImm(useImmB), .imm(immB),
        .regData1(readDataB1), .regData2(readDataB2), .sel1(selB1), .sel2(selB2),
        .otherXmResult(xmResultA), .otherMwResult(wbDataA),
        .src1(srcB1), .src2(srcB2),
        .xmWrite(xmWriteB), .xmRd(xmRdB), .xmResult(xmResultB),
        .mwWrite(wbEnableB), .mwRd(wbRegB), .mwResult(wbDataB)
    );

endmodule

`default_nettype wire

//--- design/dualIssuePkg.sv
`default_nettype none

package dualIssuePkg;

    typedef logic [31:0] dataWord;
    typedef logic [4:0]  regIndex;

    // opcodes the core executes, all others retire as no-write
    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLui   = 7'b0110111;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10  // lui
    } aluOp;

    // operand source codes
    typedef enum logic [2:0] {
        fromRegFile = 3'b000,
        fromXmA     = 3'b010,
        fromXmB     = 3'b011,
        fromMwA     = 3'b100,
        fromMwB     = 3'b101
    } fwdSel;

endpackage

`default_nettype wire

//--- design/execLane.sv
`timescale 1ns/1ps
`default_nettype none

module execLane (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  isLaneB,  // which bypass codes point at this lane
    input  logic                  valid,
    input  dualIssuePkg::regIndex rs1,
    input  dualIssuePkg::regIndex rs2,
    input  dualIssuePkg::regIndex rd,
    input  logic                  writesReg,
    input  dualIssuePkg::aluOp    op,
    input  logic                  useImm,
    input  dualIssuePkg::dataWord imm,
    input  dualIssuePkg::dataWord regData1,
    input  dualIssuePkg::dataWord regData2,
    input  dualIssuePkg::fwdSel   sel1,
    input  dualIssuePkg::fwdSel   sel2,
    input  dualIssuePkg::dataWord otherXmResult,
    input  dualIssuePkg::dataWord otherMwResult,
    output dualIssuePkg::regIndex src1,
    output dualIssuePkg::regIndex src2,
    output logic                  xmWrite,
    output dualIssuePkg::regIndex xmRd,
    output dualIssuePkg::dataWord xmResult,
    output logic                  mwWrite,
    output dualIssuePkg::regIndex mwRd,
    output dualIssuePkg::dataWord mwResult
);
    import dualIssuePkg::*;

    logic    dxValid;
    logic    dxWritesReg;
    logic    dxUseImm;
    regIndex dxRd;
    aluOp    dxOp;
    dataWord dxImm;
    dataWord dxData1;
    dataWord dxData2;
    dataWord xmValA, xmValB;
    dataWord mwValA, mwValB;
    dataWord operand1, operand2;
    dataWord aluResult;

    function automatic dataWord pickOperand(
        input fwdSel   sel,
        input dataWord regVal,
        input dataWord xmA,
        input dataWord xmB,
        input dataWord mwA,
        input dataWord mwB
    );
        case (sel)
            fromXmA: return xmA;
            fromXmB: return xmB;
            fromMwA: return mwA;
            fromMwB: return mwB;
            default: return regVal;
        endcase
    endfunction

    // ------ execute ------
    assign xmValA = isLaneB ? otherXmResult : xmResult;
    assign xmValB = isLaneB ? xmResult : otherXmResult;
    assign mwValA = isLaneB ? otherMwResult : mwResult;
    assign mwValB = isLaneB ? mwResult : otherMwResult;

    always_comb begin
        operand1 = pickOperand(sel1, dxData1, xmValA, xmValB, mwValA, mwValB);
        if (dxUseImm) begin
            operand2 = dxImm;
        end else begin
            operand2 = pickOperand(sel2, dxData2, xmValA, xmValB, mwValA, mwValB);
        end
    end

    alu alu0 (
        .a      (operand1),
        .b      (operand2),
        .op     (dxOp),
        .result (aluResult)
    );

    // ------ stage registers ------
    always_ff @(posedge clock) begin
        if (reset) begin
            dxValid <= 1'b0;
            xmWrite <= 1'b0;
            mwWrite <= 1'b0;
        end else begin
            dxValid <= valid;
            xmWrite <= dxValid && dxWritesReg && (dxRd != '0);  // no x0 writeback
            mwWrite <= xmWrite;
        end
    end

    always_ff @(posedge clock) begin
        src1        <= rs1;
        src2        <= rs2;
        dxRd        <= rd;
        dxWritesReg <= writesReg;
        dxOp        <= op;
        dxUseImm    <= useImm;
        dxImm       <= imm;
        dxData1     <= regData1;
        dxData2     <= regData2;
        xmRd        <= dxRd;
        xmResult    <= aluResult;
        mwRd        <= xmRd;  // memory stage is a plain pass
        mwResult    <= xmResult;
    end

endmodule

`default_nettype wire

//--- design/laneDecode.sv
`timescale 1ns/1ps
`default_nettype none

module laneDecode (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issueValid,
    input  logic [31:0]           instr,
    output logic                  valid,
    output dualIssuePkg::regIndex rs1,
    output dualIssuePkg::regIndex rs2,
    output dualIssuePkg::regIndex rd,
    output logic                  writesReg,
    output dualIssuePkg::aluOp    op,
    output logic                  useImm,
    output dualIssuePkg::dataWord imm
);
    import dualIssuePkg::*;

    logic [31:0] instrReg;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        altBit;  // funct7[5]

    function automatic aluOp mapFunct3(input logic [2:0] f3, input logic alt, input logic isReg);
        case (f3)
            3'b000:  mapFunct3 = (alt && isReg) ? aluSub : aluAdd;  // no subi
            3'b001:  mapFunct3 = aluSll;
            3'b010:  mapFunct3 = aluSlt;
            3'b011:  mapFunct3 = aluSltu;
            3'b100:  mapFunct3 = aluXor;
            3'b101:  mapFunct3 = alt ? aluSra : aluSrl;
            3'b110:  mapFunct3 = aluOr;
            default: mapFunct3 = aluAnd;
        endcase
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= issueValid;
        end
    end

    always_ff @(posedge clock) begin
        if (issueValid) begin
            instrReg <= instr;
        end
    end

    assign opcode = instrReg[6:0];
    assign funct3 = instrReg[14:12];
    assign altBit = instrReg[30];

    always_comb begin
        rs1       = '0;  // unused sources read x0
        rs2       = '0;
        rd        = instrReg[11:7];
        writesReg = 1'b0;
        op        = aluAdd;
        useImm    = 1'b0;
        imm       = '0;
        case (opcode)
            opOp: begin
                rs1       = instrReg[19:15];
                rs2       = instrReg[24:20];
                writesReg = 1'b1;
                op        = mapFunct3(funct3, altBit, 1'b1);
            end
            opOpImm: begin
                rs1       = instrReg[19:15];
                writesReg = 1'b1;
                op        = mapFunct3(funct3, altBit, 1'b0);
                useImm    = 1'b1;
                imm       = {{20{instrReg[31]}}, instrReg[31:20]};
            end
            opLui: begin
                writesReg = 1'b1;
                op        = aluPassB;
                useImm    = 1'b1;
                imm       = {instrReg[31:12], 12'b0};
            end
            default: begin
                writesReg = 1'b0;  // anything else flows through as a bubble
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                  clock,
    input  logic                  reset,
    input  dualIssuePkg::regIndex readRegA1,
    input  dualIssuePkg::regIndex readRegA2,
    input  dualIssuePkg::regIndex readRegB1,
    input  dualIssuePkg::regIndex readRegB2,
    output dualIssuePkg::dataWord readDataA1,
    output dualIssuePkg::dataWord readDataA2,
    output dualIssuePkg::dataWord readDataB1,
    output dualIssuePkg::dataWord readDataB2,
    input  logic                  writeEnableA,
    input  dualIssuePkg::regIndex writeRegA,
    input  dualIssuePkg::dataWord writeDataA,
    input  logic                  writeEnableB,
    input  dualIssuePkg::regIndex writeRegB,
    input  dualIssuePkg::dataWord writeDataB
);
    import dualIssuePkg::*;

    dataWord regs [32];

    // write-through, lane B is the newer writer
    function automatic dataWord readPort(input regIndex addr);
        if (addr == '0) begin
            return '0;
        end else if (writeEnableB && writeRegB == addr) begin
            return writeDataB;
        end else if (writeEnableA && writeRegA == addr) begin
            return writeDataA;
        end
        return regs[addr];
    endfunction

    always_comb begin
        readDataA1 = readPort(readRegA1);
        readDataA2 = readPort(readRegA2);
        readDataB1 = readPort(readRegB1);
        readDataB2 = readPort(readRegB2);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (writeEnableA && writeRegA != '0) begin
                regs[writeRegA] <= writeDataA;
            end
            if (writeEnableB && writeRegB != '0) begin
                regs[writeRegB] <= writeDataB;  // overrides A on same reg
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/dualAluCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module dualAluCoreTb;
    import dualIssuePkg::*;

    localparam int numCycles     = 2000;
    localparam int timeoutCycles = numCycles + 20;  // reset and drain fit in the margin

    logic        clock;
    logic        reset;
    logic        issueValid;
    logic [31:0] instrA;
    logic [31:0] instrB;
    logic        wbEnableA;
    regIndex     wbRegA;
    dataWord     wbDataA;
    logic        wbEnableB;
    regIndex     wbRegB;
    dataWord     wbDataB;

    dataWord modelRegs [32];
    logic    expEnA [8];  // indexed by check cycle mod 8
    regIndex expRegA [8];
    dataWord expDataA [8];
    logic    expEnB [8];
    regIndex expRegB [8];
    dataWord expDataB [8];
    int      edgeCount = 0;
    int      checkCount = 0;
    int      errorCount = 0;
    int      totalErrors;

    dualAluCore dut0 (
        .clock(clock), .reset(reset), .issueValid(issueValid),
        .instrA(instrA), .instrB(instrB),
        .wbEnableA(wbEnableA), .wbRegA(wbRegA), .wbDataA(wbDataA),
        .wbEnableB(wbEnableB), .wbRegB(wbRegB), .wbDataB(wbDataB)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // --------------------
    // instruction source
    // --------------------
    function automatic logic [31:0] randomInstr();
        int          pick;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [6:0]  f7;
        pick  = $urandom % 16;
        rd    = $urandom % 8;  // x0..x7 keeps hazards dense
        rs1   = $urandom % 8;
        rs2   = $urandom % 8;
        f3    = $urandom % 8;
        imm   = $urandom;
        upper = $urandom;
        f7    = 7'b0;
        if (($urandom % 2) == 1 && (f3 == 3'b000 || f3 == 3'b101)) begin
            f7 = 7'b0100000;  // sub, sra
        end
        if (pick < 6) begin
            return {f7, rs2, rs1, f3, rd, opOp};
        end else if (pick < 12) begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm = {f7, imm[4:0]};  // shift immediates
            end
            return {imm, rs1, f3, rd, opOpImm};
        end else if (pick < 14) begin
            return {upper, rd, opLui};
        end else if (pick == 14) begin
            return {imm, rs1, 3'b010, rd, 7'b0000011};  // lw
        end
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b1100011};  // beq
    endfunction

    // ISA result of one instruction on the model state
    task automatic modelInstr(input logic [31:0] instr, output logic en,
                              output regIndex rd, output dataWord data);
        dataWord    v1;
        dataWord    v2;
        logic [2:0] f3;
        logic       known;
        v1    = modelRegs[instr[19:15]];
        v2    = modelRegs[instr[24:20]];
        f3    = instr[14:12];
        rd    = instr[11:7];
        known = 1'b1;
        data  = '0;
        if (instr[6:0] == opOpImm) begin
            v2 = {{20{instr[31]}}, instr[31:20]};
        end
        case (instr[6:0])
            opOp, opOpImm: begin
                case (f3)
                    3'b000: data = (instr[30] && instr[6:0] == opOp) ? v1 - v2 : v1 + v2;
                    3'b001: data = v1 << v2[4:0];
                    3'b010: data = ($signed(v1) < $signed(v2)) ? 32'd1 : 32'd0;
                    3'b011: data = (v1 < v2) ? 32'd1 : 32'd0;
                    3'b100: data = v1 ^ v2;
                    3'b101: begin
                        if (instr[30]) begin
                            data = $signed(v1) >>> v2[4:0];
                        end else begin
                            data = v1 >> v2[4:0];
                        end
                    end
                    3'b110: data = v1 | v2;
                    default: data = v1 & v2;
                endcase
            end
            opLui: data = {instr[31:12], 12'b0};
            default: known = 1'b0;  // load, branch: no write
        endcase
        en = known && (rd != 5'd0);
    endtask

    task automatic drivePair(input logic issue);
        logic [31:0] a;
        logic [31:0] b;
        logic        enA;
        logic        enB;
        regIndex     rdA;
        regIndex     rdB;
        dataWord     dA;
        dataWord     dB;
        int          slot;
        a    = randomInstr();
        b    = randomInstr();
        slot = (edgeCount + 5) % 8;  // seen at edge n+1, on writeback after n+4
        issueValid <= issue;
        instrA     <= a;
        instrB     <= b;
        enA = 1'b0;
        enB = 1'b0;
        rdA = '0;
        rdB = '0;
        dA  = '0;
        dB  = '0;
        if (issue) begin
            modelInstr(a, enA, rdA, dA);  // both read pre-pair state
            modelInstr(b, enB, rdB, dB);
            if (enA) begin
                modelRegs[rdA] = dA;
            end
            if (enB) begin
                modelRegs[rdB] = dB;  // B is newer
            end
        end
        expEnA[slot]   = enA;
        expRegA[slot]  = rdA;
        expDataA[slot] = dA;
        expEnB[slot]   = enB;
        expRegB[slot]  = rdB;
        expDataB[slot] = dB;
    endtask

    always @(posedge clock) begin
        edgeCount <= edgeCount + 1;
    end

    always @(posedge clock) begin
        if (edgeCount >= timeoutCycles) begin
            $display("timeout: run still going after %0d cycles", timeoutCycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clock) begin
        int slot;
        slot = edgeCount % 8;
        if (edgeCount >= 2) begin
            checkValue("wbEnableA", wbEnableA, expEnA[slot]);
            checkValue("wbEnableB", wbEnableB, expEnB[slot]);
            if (expEnA[slot]) begin
                checkValue("wbRegA", wbRegA, expRegA[slot]);
                checkValue("wbDataA", wbDataA, expDataA[slot]);
            end
            if (expEnB[slot]) begin
                checkValue("wbRegB", wbRegB, expRegB[slot]);
                checkValue("wbDataB", wbDataB, expDataB[slot]);
            end
        end
    end

    initial begin
        reset      = 1'b1;
        issueValid = 1'b0;
        instrA     = '0;
        instrB     = '0;
        void'($urandom(14));
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            expEnA[i] = 1'b0;
            expEnB[i] = 1'b0;
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < numCycles; i++) begin
            @(posedge clock);
            drivePair(($urandom % 4) != 0);  // about 75% issue
        end
        repeat (6) begin
            @(posedge clock);
            drivePair(1'b0);  // drain
        end
        @(negedge clock);
        #1;
        totalErrors = errorCount + dut0.asserts0.assertFails;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checkCount, errorCount, dut0.asserts0.assertFails);
        if (totalErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/dualAluCore_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dualAluCoreAsserts (
    input logic                  clock,
    input logic                  reset,
    input logic                  issueValid,
    input logic                  wbEnableA,
    input dualIssuePkg::regIndex wbRegA,
    input logic                  wbEnableB,
    input dualIssuePkg::regIndex wbRegB
);
    import dualIssuePkg::*;

    int assertFails = 0;  // read by the testbench

    // --------------------
    // writeback sanity
    // --------------------
    noX0WriteA: assert property (@(posedge clock) disable iff (reset)
        wbEnableA |-> wbRegA != 5'd0)
        else begin assertFails++; $error("lane A writeback enabled for x0"); end

    noX0WriteB: assert property (@(posedge clock) disable iff (reset)
        wbEnableB |-> wbRegB != 5'd0)
        else begin assertFails++; $error("lane B writeback enabled for x0"); end

    // pair sampled at edge k is seen on writeback at edge k+4
    issuedA: assert property (@(posedge clock) disable iff (reset)
        wbEnableA |-> $past(issueValid, 4))
        else begin assertFails++; $error("lane A writeback without an issue"); end

    issuedB: assert property (@(posedge clock) disable iff (reset)
        wbEnableB |-> $past(issueValid, 4))
        else begin assertFails++; $error("lane B writeback without an issue"); end

    // --------------------
    // quiet around reset
    // --------------------
    quietInReset: assert property (@(posedge clock)
        reset |=> (!wbEnableA && !wbEnableB))
        else begin assertFails++; $error("writeback enabled during reset"); end

    quietAfterReset: assert property (@(posedge clock)
        $fell(reset) |=> (!wbEnableA && !wbEnableB))
        else begin assertFails++; $error("writeback enabled right after reset"); end

endmodule

bind dualAluCore dualAluCoreAsserts asserts0 (
    .clock(clock), .reset(reset), .issueValid(issueValid),
    .wbEnableA(wbEnableA), .wbRegA(wbRegA),
    .wbEnableB(wbEnableB), .wbRegB(wbRegB)
);

`default_nettype wire
